/* files.f */
+incdir+logic
logic/cpu_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/pipeline_core.sv
sim/tb_ref_model.sv
sim/tb_pipeline_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipeline_core
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

FILELIST := files.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard logic/*.svh)
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when the file list or a source changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^Result: PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_pipeline_core.sv */
`default_nettype none

`include "cpu_defines.svh"

module tb_pipeline_core;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int MEM_AW       = 8;
   localparam int MEM_DEPTH    = 1 << MEM_AW;
   localparam int NUM_PROGS    = 2;
   localparam int RAND_LEN     = 48;
   localparam int HOLD_CYCLES  = 8;
   localparam int WATCH_SLACK  = 20;

   logic                   clk = 1'b0;
   logic                   reset_n = 1'b0;
   logic [`CPU_WORD_W-1:0] i_i_data;
   logic [`CPU_WORD_W-1:0] o_i_address;
   logic                   o_i_read;
   logic [`CPU_WORD_W-1:0] o_output_port;
   logic                   o_is_halted;
   logic [`CPU_WORD_W-1:0] o_num_inst;

   logic [`CPU_WORD_W-1:0] mem [MEM_DEPTH];
   int                     prog_len;
   int                     prog_idx;
   int                     wd_cycles = 0;
   logic [`CPU_WORD_W-1:0] last_port = '0;
   logic                   halted_seen = 1'b0;

   pipeline_core u_dut (
      .clk           (clk),
      .reset_n       (reset_n),
      .o_i_address   (o_i_address),
      .o_i_read      (o_i_read),
      .i_i_data      (i_i_data),
      .o_output_port (o_output_port),
      .o_is_halted   (o_is_halted),
      .o_num_inst    (o_num_inst)
   );

   tb_ref_model #(.AW(MEM_AW)) u_ref (
      .i_prog (mem)
   );

   //////////////////////////////////////////////////////////////////////
   // error exits
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopped on first error");
   endtask

   task automatic report_mismatch(input string sig, input logic [`CPU_WORD_W-1:0] got,
                                  input logic [`CPU_WORD_W-1:0] exp);
      abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, sig, got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // program building
   //////////////////////////////////////////////////////////////////////

   function automatic logic [`CPU_WORD_W-1:0] enc_r(input logic [5:0] fn, input logic [1:0] rs,
                                                    input logic [1:0] rt, input logic [1:0] rd);
      return {`OP_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic logic [`CPU_WORD_W-1:0] enc_i(input logic [3:0] op, input logic [1:0] rs,
                                                    input logic [1:0] rt, input logic [7:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // opcode 1 is undefined so a stray fetch past HLT does nothing
   function automatic logic [`CPU_WORD_W-1:0] fill_word(input logic [`CPU_WORD_W-1:0] addr);
      return {4'h1, addr[11:0] ^ {8'h00, addr[15:12]}};
   endfunction

   task automatic emit(input logic [`CPU_WORD_W-1:0] word);
      mem[prog_len[MEM_AW-1:0]] = word;
      prog_len++;
   endtask

   // WWD of one register
   task automatic show(input logic [1:0] r);
      emit(enc_r(`FN_WWD, r, 2'd0, 2'd0));
   endtask

   // r2 = op(rs, r1) shown right away through forwarding
   task automatic alu_and_show(input logic [5:0] fn, input logic [1:0] rs);
      emit(enc_r(fn, rs, 2'd1, 2'd2));
      show(2'd2);
   endtask

   task automatic build_directed();
      // r0 = 1234 and r1 = 80f0 with each ORI right behind its LHI
      emit(enc_i(`OP_LHI, 2'd0, 2'd0, 8'h12));
      emit(enc_i(`OP_ORI, 2'd0, 2'd0, 8'h34));
      emit(enc_i(`OP_LHI, 2'd0, 2'd1, 8'h80));
      emit(enc_i(`OP_ORI, 2'd1, 2'd1, 8'hf0));
      show(2'd0);
      show(2'd1);
      // byte 85 sign extended by ADI and zero extended by ORI
      emit(enc_i(`OP_ADI, 2'd0, 2'd2, 8'h85));
      show(2'd2);
      emit(enc_i(`OP_ORI, 2'd3, 2'd3, 8'h85));
      show(2'd3);
      emit(enc_i(`OP_ADI, 2'd3, 2'd3, 8'hff));
      show(2'd3);
      // all eight alu functions
      alu_and_show(`FN_ADD, 2'd0);
      alu_and_show(`FN_SUB, 2'd0);
      alu_and_show(`FN_AND, 2'd0);
      alu_and_show(`FN_ORR, 2'd0);
      alu_and_show(`FN_NOT, 2'd0);
      alu_and_show(`FN_TCP, 2'd0);
      alu_and_show(`FN_SHL, 2'd0);
      alu_and_show(`FN_SHR, 2'd0);
      // negative operand for the arithmetic shift
      alu_and_show(`FN_SHR, 2'd1);
      alu_and_show(`FN_TCP, 2'd1);
      // r3 at distance two and r2 at distance one
      emit(enc_r(`FN_ADD, 2'd0, 2'd1, 2'd3));
      emit(enc_i(`OP_ADI, 2'd2, 2'd2, 8'h01));
      emit(enc_r(`FN_SUB, 2'd3, 2'd2, 2'd0));
      show(2'd0);
      // undefined opcode is counted only
      emit(enc_i(4'd2, 2'd0, 2'd0, 8'h00));
      emit(enc_i(`OP_ADI, 2'd1, 2'd1, 8'h01));
      emit(enc_i(`OP_ADI, 2'd1, 2'd1, 8'h01));
      emit(enc_i(`OP_ADI, 2'd1, 2'd1, 8'h01));
      show(2'd1);
   endtask

   task automatic build_random(input int count);
      int          i;
      int unsigned kind;
      logic [1:0]  ra;
      logic [1:0]  rb;
      logic [1:0]  rc;
      logic [7:0]  imm;

      for (i = 0; i < count; i++) begin
         kind = $urandom_range(9, 0);
         ra   = 2'($urandom());
         rb   = 2'($urandom());
         rc   = 2'($urandom());
         imm  = 8'($urandom());
         case (kind)
            5: emit(enc_i(`OP_ADI, ra, rb, imm));
            6: emit(enc_i(`OP_ORI, ra, rb, imm));
            7: emit(enc_i(`OP_LHI, ra, rb, imm));
            8, 9: show(ra);
            // alu functions 0 to 7
            default: emit(enc_r(6'($urandom_range(7, 0)), ra, rb, rc));
         endcase
      end
   endtask

   task automatic build_program();
      int i;

      for (i = 0; i < MEM_DEPTH; i++) begin
         mem[i[MEM_AW-1:0]] = fill_word(16'(i));
      end
      prog_len = 0;
      build_directed();
      build_random(RAND_LEN);
      emit(enc_r(`FN_HLT, 2'd0, 2'd0, 2'd0));
   endtask

   //////////////////////////////////////////////////////////////////////
   // reset and run control
   //////////////////////////////////////////////////////////////////////

   task automatic check_reset_state();
      assert (o_i_read == 1'b0) else report_mismatch("o_i_read", 16'(o_i_read), '0);
      assert (o_is_halted == 1'b0) else report_mismatch("o_is_halted", 16'(o_is_halted), '0);
      assert (o_output_port == '0) else report_mismatch("o_output_port", o_output_port, '0);
      assert (o_num_inst == '0) else report_mismatch("o_num_inst", o_num_inst, '0);
      assert (o_i_address == `CPU_RESET_PC)
         else report_mismatch("o_i_address", o_i_address, `CPU_RESET_PC);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1 reset_n = 1'b0;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_reset_state();
      @(posedge clk);
      #1 reset_n = 1'b1;
   endtask

   task automatic wait_for_halt();
      while (o_is_halted !== 1'b1) begin
         @(posedge clk);
      end
      // stay a while to see halt hold
      repeat (HOLD_CYCLES) @(posedge clk);
   endtask

   initial begin : clock_gen
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // instruction memory returns the word 5 ns after the read edge
   always @(posedge clk) begin : imem_model
      logic [`CPU_WORD_W-1:0] fetch_addr;
      if (o_i_read === 1'b1) begin
         fetch_addr = o_i_address;
         #5;
         i_i_data = mem[fetch_addr[MEM_AW-1:0]];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks sampled mid cycle
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin : output_checks
      logic [`CPU_WORD_W-1:0] exp_val;
      if (!reset_n) begin
         last_port   = '0;
         halted_seen = 1'b0;
      end else if (!halted_seen) begin
         if (o_output_port !== last_port) begin
            // a WWD of the value already held leaves no trace
            while (u_ref.exp_out.size() > 0 && u_ref.exp_out[0] == last_port) begin
               void'(u_ref.exp_out.pop_front());
            end
            assert (u_ref.exp_out.size() > 0)
               else abort_run("o_output_port changed with no WWD left in the reference");
            exp_val = u_ref.exp_out.pop_front();
            assert (o_output_port == exp_val)
               else report_mismatch("o_output_port", o_output_port, exp_val);
            last_port = o_output_port;
         end
         if (o_is_halted) begin
            assert (o_num_inst == 16'(u_ref.exp_count))
               else report_mismatch("o_num_inst", o_num_inst, 16'(u_ref.exp_count));
            // anything left must have repeated the final value
            while (u_ref.exp_out.size() > 0) begin
               exp_val = u_ref.exp_out.pop_front();
               assert (exp_val == last_port)
                  else report_mismatch("o_output_port", last_port, exp_val);
            end
            halted_seen = 1'b1;
         end
      end else begin
         assert (o_is_halted) else abort_run("o_is_halted dropped before reset");
         assert (!o_i_read) else abort_run("o_i_read went high after halt");
         assert (o_output_port == last_port)
            else report_mismatch("o_output_port", o_output_port, last_port);
      end
   end

   // program length plus slack in clock periods
   always @(posedge clk) begin : watchdog
      if (!reset_n) begin
         wd_cycles = 0;
      end else if (o_is_halted !== 1'b1) begin
         wd_cycles = wd_cycles + 1;
         if (wd_cycles > prog_len + WATCH_SLACK) begin
            abort_run($sformatf("timeout, program %0d did not halt within %0d ns",
                                prog_idx, (prog_len + WATCH_SLACK) * CLK_PERIOD));
         end
      end
   end

   initial begin : main_flow
      void'($urandom(32'h5f60));
      i_i_data = '0;
      prog_len = 0;
      for (prog_idx = 0; prog_idx < NUM_PROGS; prog_idx++) begin
         build_program();
         apply_reset();
         // model reads the program through its port
         u_ref.run(prog_len);
         wait_for_halt();
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/tb_ref_model.sv */
`default_nettype none

`include "cpu_defines.svh"

module tb_ref_model #(
   parameter int AW    = 8,
   parameter int DEPTH = 1 << AW
) (
   input wire logic [`CPU_WORD_W-1:0] i_prog [DEPTH]
);

   timeunit 1ns;
   timeprecision 1ps;

   // port values in WWD order
   logic [`CPU_WORD_W-1:0] exp_out [$];
   // retired count, HLT included
   int unsigned            exp_count;

   // one instruction at a time, registers start at zero
   task automatic run(input int len);
      logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];
      logic [`CPU_WORD_W-1:0] word;
      logic [`CPU_WORD_W-1:0] a;
      logic [`CPU_WORD_W-1:0] b;
      logic [3:0]             op;
      logic [1:0]             rs;
      logic [1:0]             rt;
      logic [1:0]             rd;
      logic [5:0]             fn;
      logic [7:0]             imm;
      logic                   halted;
      int                     pc;
      int                     i;

      exp_out.delete();
      exp_count = 0;
      halted    = 1'b0;
      pc        = 0;
      for (i = 0; i < `CPU_NUM_REGS; i++) begin
         regs[i] = '0;
      end
      while (!halted && pc < len) begin
         word = i_prog[pc[AW-1:0]];
         // fields at fixed places in the word
         op   = word[15:12];
         rs   = word[11:10];
         rt   = word[9:8];
         rd   = word[7:6];
         fn   = word[5:0];
         imm  = word[7:0];
         a    = regs[rs];
         b    = regs[rt];
         exp_count++;
         pc++;
         case (op)
            `OP_ADI: regs[rt] = a + {{8{imm[7]}}, imm};
            `OP_ORI: regs[rt] = a | {8'h00, imm};
            `OP_LHI: regs[rt] = {imm, 8'h00};
            `OP_RTYPE: begin
               case (fn)
                  `FN_ADD: regs[rd] = a + b;
                  `FN_SUB: regs[rd] = a - b;
                  `FN_AND: regs[rd] = a & b;
                  `FN_ORR: regs[rd] = a | b;
                  `FN_NOT: regs[rd] = ~a;
                  `FN_TCP: regs[rd] = -a;
                  `FN_SHL: regs[rd] = a << 1;
                  // sign bit copied down
                  `FN_SHR: regs[rd] = $signed(a) >>> 1;
                  `FN_WWD: exp_out.push_back(a);
                  `FN_HLT: halted = 1'b1;
                  default: ;
               endcase
            end
            // anything else retires with no effect
            default: ;
         endcase
      end
   endtask

endmodule

`default_nettype wire

/* logic/pipeline_core.sv */
`default_nettype none

`include "cpu_defines.svh"

module pipeline_core import cpu_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   reset_n,
   output logic [`CPU_WORD_W-1:0]      o_i_address,
   output logic                        o_i_read,
   input  wire logic [`CPU_WORD_W-1:0] i_i_data,
   output logic [`CPU_WORD_W-1:0]      o_output_port,
   output logic                        o_is_halted,
   output logic [`CPU_WORD_W-1:0]      o_num_inst
);

   // unknown func, no effect even if it were valid
   localparam logic [`CPU_WORD_W-1:0] NOP_WORD = {`OP_RTYPE, 6'd0, 6'h3f};

   // fetch
   logic [`CPU_WORD_W-1:0] pc;
   logic                   fetch_en;
   logic                   fetch_pending;

   // decode
   inst_u                  ir;
   logic                   ir_valid;
   ctrl_t                  id_ctrl;
   logic [`CPU_WORD_W-1:0] id_imm;
   logic [`CPU_WORD_W-1:0] rf_data_a;
   logic [`CPU_WORD_W-1:0] rf_data_b;

   // execute, writeback
   ex_stage_t              ex_q;
   wb_stage_t              wb_q;
   wb_stage_t              wb_next;
   logic [`CPU_WORD_W-1:0] ex_out_value;

   logic                   ex_halt;
   logic                   wb_halt;
   logic                   halt_in_pipe;

   //////////////////////////////////////////////////////////////////////
   // IF
   //////////////////////////////////////////////////////////////////////

   assign ex_halt      = ex_q.ctrl.valid & ex_q.ctrl.halt;
   assign wb_halt      = wb_q.valid & wb_q.halt;
   assign halt_in_pipe = id_ctrl.halt | ex_halt | wb_halt;

   // drop the strobe in the same cycle HLT sits in ID
   assign o_i_read    = fetch_en & ~id_ctrl.halt;
   assign o_i_address = pc;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc            <= `CPU_RESET_PC;
         fetch_en      <= 1'b0;
         fetch_pending <= 1'b0;
         ir            <= NOP_WORD;
         ir_valid      <= 1'b0;
      end else begin
         // off for good once HLT is seen, until reset
         fetch_en      <= ~(halt_in_pipe | o_is_halted);
         fetch_pending <= o_i_read;
         if (o_i_read) begin
            pc <= pc + `CPU_WORD_W'(1);
         end
         // word behind HLT is thrown away
         if (id_ctrl.halt || !fetch_pending) begin
            ir       <= NOP_WORD;
            ir_valid <= 1'b0;
         end else begin
            ir       <= i_i_data;
            ir_valid <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // ID
   //////////////////////////////////////////////////////////////////////

   inst_decoder u_decoder (
      .i_inst       (ir),
      .i_inst_valid (ir_valid),
      .o_ctrl       (id_ctrl),
      .o_imm        (id_imm)
   );

   // writes come from WB
   reg_file u_reg_file (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_wr_en     (wb_q.valid & wb_q.wr_en),
      .i_wr_reg    (wb_q.wr_reg),
      .i_wr_data   (wb_q.result),
      .i_rd_reg_a  (ir.r_fields.rs),
      .i_rd_reg_b  (ir.r_fields.rt),
      .o_rd_data_a (rf_data_a),
      .o_rd_data_b (rf_data_b)
   );

   // control part
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ex_q.ctrl <= '0;
      end else begin
         ex_q.ctrl <= id_ctrl;
      end
   end

   // operands and indices
   always_ff @(posedge clk) begin
      ex_q.rs  <= ir.r_fields.rs;
      ex_q.rt  <= ir.r_fields.rt;
      ex_q.a   <= rf_data_a;
      ex_q.b   <= rf_data_b;
      ex_q.imm <= id_imm;
   end

   //////////////////////////////////////////////////////////////////////
   // EX
   //////////////////////////////////////////////////////////////////////

   execute_stage u_execute (
      .i_ex        (ex_q),
      .i_wb        (wb_q),
      .o_out_value (ex_out_value),
      .o_wb_next   (wb_next)
   );

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wb_q.valid <= 1'b0;
         wb_q.wr_en <= 1'b0;
         wb_q.halt  <= 1'b0;
      end else begin
         wb_q.valid <= wb_next.valid;
         wb_q.wr_en <= wb_next.wr_en;
         wb_q.halt  <= wb_next.halt;
      end
   end

   always_ff @(posedge clk) begin
      wb_q.wr_reg <= wb_next.wr_reg;
      wb_q.result <= wb_next.result;
   end

   //////////////////////////////////////////////////////////////////////
   // WB side effects, output port, halt, retire count
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_output_port <= '0;
         o_is_halted   <= 1'b0;
         o_num_inst    <= '0;
      end else begin
         // WWD at end of its EX cycle
         if (ex_q.ctrl.valid && ex_q.ctrl.out_wr) begin
            o_output_port <= ex_out_value;
         end
         if (wb_halt) begin
            o_is_halted <= 1'b1;
         end
         // HLT counts too
         if (wb_q.valid) begin
            o_num_inst <= o_num_inst + `CPU_WORD_W'(1);
         end
      end
   end

   // halted is sticky and fetch stays off
   a_halt_sticky: assert property (
      @(posedge clk) disable iff (!reset_n)
      o_is_halted |=> o_is_halted && !o_i_read
   );

   // HLT past ID must have shut fetch already
   a_no_fetch_behind_halt: assert property (
      @(posedge clk) disable iff (!reset_n)
      (ex_halt || wb_halt) |-> !$rose(o_i_read)
   );

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

`include "cpu_defines.svh"

module execute_stage import cpu_pkg::*; (
   input  wire ex_stage_t          i_ex,
   input  wire wb_stage_t          i_wb,
   output logic [`CPU_WORD_W-1:0]  o_out_value,
   output wb_stage_t               o_wb_next
);

   logic                   fwd_a_hit;
   logic                   fwd_b_hit;
   logic [`CPU_WORD_W-1:0] op_a;
   logic [`CPU_WORD_W-1:0] fwd_b;
   logic [`CPU_WORD_W-1:0] op_b;
   logic [`CPU_WORD_W-1:0] result;

   //////////////////////////////////////////////////////////////////////
   // operand forwarding
   //////////////////////////////////////////////////////////////////////

   // wb holds the instruction one ahead
   assign fwd_a_hit = i_wb.valid && i_wb.wr_en && (i_wb.wr_reg == i_ex.rs);
   assign fwd_b_hit = i_wb.valid && i_wb.wr_en && (i_wb.wr_reg == i_ex.rt);

   assign op_a  = fwd_a_hit ? i_wb.result : i_ex.a;
   assign fwd_b = fwd_b_hit ? i_wb.result : i_ex.b;

   // immediate replaces rt
   assign op_b = i_ex.ctrl.use_imm ? i_ex.imm : fwd_b;

   //////////////////////////////////////////////////////////////////////
   // alu
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      result = '0;
      case (i_ex.ctrl.alu_op)
         ALU_ADD:  result = op_a + op_b;
         ALU_SUB:  result = op_a - op_b;
         ALU_AND:  result = op_a & op_b;
         ALU_ORR:  result = op_a | op_b;
         // b - a, NOT with b all ones, TCP with b zero
         ALU_RSB:  result = op_b - op_a;
         ALU_SHL:  result = {op_a[`CPU_WORD_W-2:0], 1'b0};
         // arithmetic, sign bit kept
         ALU_SHR:  result = {op_a[`CPU_WORD_W-1], op_a[`CPU_WORD_W-1:1]};
         ALU_PASS: result = op_b;
         default:  result = '0;
      endcase
   end

   // WWD reads the forwarded rs
   assign o_out_value = op_a;

   //////////////////////////////////////////////////////////////////////
   // next wb contents
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      o_wb_next.valid  = i_ex.ctrl.valid;
      o_wb_next.wr_en  = i_ex.ctrl.valid & i_ex.ctrl.wr_en;
      o_wb_next.wr_reg = i_ex.ctrl.wr_reg;
      o_wb_next.halt   = i_ex.ctrl.valid & i_ex.ctrl.halt;
      o_wb_next.result = result;
   end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
   input  wire logic                      clk,
   input  wire logic                      reset_n,
   input  wire logic                      i_wr_en,
   input  wire logic [`CPU_REG_IDX_W-1:0] i_wr_reg,
   input  wire logic [`CPU_WORD_W-1:0]    i_wr_data,
   input  wire logic [`CPU_REG_IDX_W-1:0] i_rd_reg_a,
   input  wire logic [`CPU_REG_IDX_W-1:0] i_rd_reg_b,
   output logic [`CPU_WORD_W-1:0]         o_rd_data_a,
   output logic [`CPU_WORD_W-1:0]         o_rd_data_b
);

   logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en) begin
         regs[i_wr_reg] <= i_wr_data;
      end
   end

   // write-through, covers the distance-two dependency
   assign o_rd_data_a = (i_wr_en && i_wr_reg == i_rd_reg_a) ? i_wr_data : regs[i_rd_reg_a];
   assign o_rd_data_b = (i_wr_en && i_wr_reg == i_rd_reg_b) ? i_wr_data : regs[i_rd_reg_b];

   // x on the write path means a stage upstream lost its data
   a_wr_data_known: assert property (
      @(posedge clk) disable iff (!reset_n)
      i_wr_en |-> !$isunknown(i_wr_data)
   );

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`default_nettype none

`include "cpu_defines.svh"

module inst_decoder import cpu_pkg::*; (
   input  wire inst_u                i_inst,
   input  wire logic                 i_inst_valid,
   output ctrl_t                     o_ctrl,
   output logic [`CPU_WORD_W-1:0]    o_imm
);

   logic [3:0] opcode;
   logic [5:0] func;
   logic [7:0] imm8;

   // opcode and imm from the immediate view, func from the r view
   assign opcode = i_inst.i_fields.opcode;
   assign imm8   = i_inst.i_fields.imm;
   assign func   = i_inst.r_fields.func;

   always_comb begin
      // default: counted but no effect
      o_ctrl         = '0;
      o_ctrl.valid   = 1'b1;
      o_ctrl.alu_op  = ALU_ADD;
      o_imm          = '0;

      case (opcode)
         `OP_ADI: begin
            o_ctrl.alu_op  = ALU_ADD;
            o_ctrl.use_imm = 1'b1;
            o_ctrl.wr_en   = 1'b1;
            o_ctrl.wr_reg  = i_inst.i_fields.rt;
            o_imm          = {{(`CPU_WORD_W-8){imm8[7]}}, imm8};
         end
         `OP_ORI: begin
            o_ctrl.alu_op  = ALU_ORR;
            o_ctrl.use_imm = 1'b1;
            o_ctrl.wr_en   = 1'b1;
            o_ctrl.wr_reg  = i_inst.i_fields.rt;
            o_imm          = {{(`CPU_WORD_W-8){1'b0}}, imm8};
         end
         `OP_LHI: begin
            // byte goes high, low byte zero
            o_ctrl.alu_op  = ALU_PASS;
            o_ctrl.use_imm = 1'b1;
            o_ctrl.wr_en   = 1'b1;
            o_ctrl.wr_reg  = i_inst.i_fields.rt;
            o_imm          = {imm8, 8'h00};
         end
         `OP_RTYPE: begin
            // alu results land in rd
            o_ctrl.wr_reg = i_inst.r_fields.rd;
            case (func)
               `FN_ADD: begin
                  o_ctrl.alu_op = ALU_ADD;
                  o_ctrl.wr_en  = 1'b1;
               end
               `FN_SUB: begin
                  o_ctrl.alu_op = ALU_SUB;
                  o_ctrl.wr_en  = 1'b1;
               end
               `FN_AND: begin
                  o_ctrl.alu_op = ALU_AND;
                  o_ctrl.wr_en  = 1'b1;
               end
               `FN_ORR: begin
                  o_ctrl.alu_op = ALU_ORR;
                  o_ctrl.wr_en  = 1'b1;
               end
               `FN_NOT: begin
                  // ~a == all ones minus a
                  o_ctrl.alu_op  = ALU_RSB;
                  o_ctrl.use_imm = 1'b1;
                  o_ctrl.wr_en   = 1'b1;
                  o_imm          = '1;
               end
               `FN_TCP: begin
                  // -a == zero minus a
                  o_ctrl.alu_op  = ALU_RSB;
                  o_ctrl.use_imm = 1'b1;
                  o_ctrl.wr_en   = 1'b1;
               end
               `FN_SHL: begin
                  o_ctrl.alu_op = ALU_SHL;
                  o_ctrl.wr_en  = 1'b1;
               end
               `FN_SHR: begin
                  o_ctrl.alu_op = ALU_SHR;
                  o_ctrl.wr_en  = 1'b1;
               end
               `FN_WWD: o_ctrl.out_wr = 1'b1;
               `FN_HLT: o_ctrl.halt   = 1'b1;
               default: ;
            endcase
         end
         default: ;
      endcase

      // bubble in IR
      if (!i_inst_valid) begin
         o_ctrl = '0;
      end
   end

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

   //////////////////////////////////////////////////////////////////////
   // instruction word
   //////////////////////////////////////////////////////////////////////

   // register-register view
   typedef struct packed {
      logic [3:0]                opcode;
      logic [`CPU_REG_IDX_W-1:0] rs;
      logic [`CPU_REG_IDX_W-1:0] rt;
      logic [`CPU_REG_IDX_W-1:0] rd;
      logic [5:0]                func;
   } r_fields_t;

   // immediate view
   typedef struct packed {
      logic [3:0]                opcode;
      logic [`CPU_REG_IDX_W-1:0] rs;
      logic [`CPU_REG_IDX_W-1:0] rt;
      logic [7:0]                imm;
   } i_fields_t;

   // same word, two decodes
   typedef union packed {
      r_fields_t r_fields;
      i_fields_t i_fields;
   } inst_u;

   //////////////////////////////////////////////////////////////////////
   // control and stage records
   //////////////////////////////////////////////////////////////////////

   // rsb is b - a, covers NOT and TCP
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_ORR,
      ALU_RSB,
      ALU_SHL,
      ALU_SHR,
      ALU_PASS
   } alu_op_e;

   typedef struct packed {
      logic                      valid;
      alu_op_e                   alu_op;
      logic                      use_imm;
      logic                      wr_en;
      logic [`CPU_REG_IDX_W-1:0] wr_reg;
      logic                      out_wr;
      logic                      halt;
   } ctrl_t;

   // ID -> EX
   typedef struct packed {
      ctrl_t                     ctrl;
      logic [`CPU_REG_IDX_W-1:0] rs;
      logic [`CPU_REG_IDX_W-1:0] rt;
      logic [`CPU_WORD_W-1:0]    a;
      logic [`CPU_WORD_W-1:0]    b;
      logic [`CPU_WORD_W-1:0]    imm;
   } ex_stage_t;

   // EX -> WB
   typedef struct packed {
      logic                      valid;
      logic                      wr_en;
      logic [`CPU_REG_IDX_W-1:0] wr_reg;
      logic                      halt;
      logic [`CPU_WORD_W-1:0]    result;
   } wb_stage_t;

endpackage

`default_nettype wire

/* logic/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// word and register file geometry
`define CPU_WORD_W     16
`define CPU_NUM_REGS   4
`define CPU_REG_IDX_W  2

// opcodes
`define OP_ADI    4'd4
`define OP_ORI    4'd5
`define OP_LHI    4'd6
`define OP_RTYPE  4'd15

// function codes of the register-register group
`define FN_ADD  6'd0
`define FN_SUB  6'd1
`define FN_AND  6'd2
`define FN_ORR  6'd3
`define FN_NOT  6'd4
`define FN_TCP  6'd5
`define FN_SHL  6'd6
`define FN_SHR  6'd7
`define FN_WWD  6'd28
`define FN_HLT  6'd29

// first fetch address
`define CPU_RESET_PC  16'd0

`endif
